/* pcm_audio_port.f */
+incdir+include
verilog/pcm_audio_pkg.sv
verilog/pcm_link_pkg.sv
verilog/sample_credit_fifo.sv
verilog/dsp_frame_serializer.sv
verilog/pcm_audio_port.sv
testbench/tb_clock_gen.sv
testbench/pcm_audio_port_tb.sv

/* Makefile */
# Verilator build of the PCM audio port testbench
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := pcm_audio_port_tb
FILELIST  := pcm_audio_port.f
BUILD     := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

/* testbench/pcm_audio_port_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "pcm_audio_consts.svh"

module pcm_audio_port_tb;

  // Frame budget covers every sync period plus extra data phases and settling
  localparam int  FRAME_CYCLES = 65;
  localparam int  NUM_FRAMES   = 56;
  localparam real TIMEOUT_NS   = NUM_FRAMES * FRAME_CYCLES * 40 * 1.5;

  logic                          ac_bclk;
  logic                          rst_n;
  pcm_audio_pkg::word_length_t   word_length;
  logic                          ac_pblrc;
  logic                          ac_pbdat;
  logic                          ac_recdat;
  logic                          ac_reclrc;
  pcm_link_pkg::play_push_t      play_in;
  pcm_link_pkg::credit_t         play_credit;
  pcm_link_pkg::rec_push_t       rec_out;
  pcm_link_pkg::credit_t         rec_credit;

  // Expected traffic and counters
  pcm_audio_pkg::stereo_sample_t play_exp[$];
  pcm_audio_pkg::capture_frame_t rec_exp[$];
  int play_pushes  = 0;
  int play_gives   = 0;
  int rec_received = 0;
  int rec_pending  = 0;
  bit rec_hold     = 1'b0;
  bit next_overrun = 1'b0;

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(2)) clk_i (
    .ac_bclk(ac_bclk),
    .rst_n  (rst_n)
  );

  pcm_audio_port dut_i (
    .ac_bclk    (ac_bclk),
    .rst_n      (rst_n),
    .word_length(word_length),
    .ac_pblrc   (ac_pblrc),
    .ac_pbdat   (ac_pbdat),
    .ac_recdat  (ac_recdat),
    .ac_reclrc  (ac_reclrc),
    .play_in    (play_in),
    .play_credit(play_credit),
    .rec_out    (rec_out),
    .rec_credit (rec_credit)
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic int word_bits(input pcm_audio_pkg::word_length_t wl);
    case (wl)
      pcm_audio_pkg::WL_16: return 16;
      pcm_audio_pkg::WL_20: return 20;
      pcm_audio_pkg::WL_24: return 24;
      default:              return 32;
    endcase
  endfunction

  // Left field at the top with the right field below and a zero tail
  function automatic logic [63:0] play_bits(input pcm_audio_pkg::stereo_sample_t s,
                                            input pcm_audio_pkg::word_length_t wl);
    int          n;
    logic [63:0] mask;
    logic [63:0] l;
    logic [63:0] r;
    n    = word_bits(wl);
    mask = (64'd1 << n) - 64'd1;
    l    = {32'd0, s.left} & mask;
    r    = {32'd0, s.right} & mask;
    return (l << (64 - n)) | (r << (64 - 2 * n));
  endfunction

  // First bit received is the frame MSB
  function automatic pcm_audio_pkg::stereo_sample_t rec_frame(input logic [63:0] b,
                                                              input pcm_audio_pkg::word_length_t wl);
    int                            n;
    logic [63:0]                   mask;
    pcm_audio_pkg::stereo_sample_t s;
    n       = word_bits(wl);
    mask    = (64'd1 << n) - 64'd1;
    s.left  = 32'((b >> (64 - n)) & mask);
    s.right = 32'((b >> (64 - 2 * n)) & mask);
    return s;
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_pbdat(input logic exp, input logic act);
    if (act !== exp) begin
      report_fail($sformatf("FAIL t=%0t ac_pbdat exp=%b got=%b", $time, exp, act));
    end
  endtask

  task automatic check_rec_frame(input pcm_audio_pkg::capture_frame_t exp,
                                 input pcm_audio_pkg::capture_frame_t act);
    if (act !== exp) begin
      report_fail($sformatf("FAIL t=%0t rec_out.data exp=%h got=%h", $time, exp, act));
    end
  endtask

  task automatic check_credits(input string name, input int exp, input int act);
    if (act != exp) begin
      report_fail($sformatf("FAIL t=%0t %s exp=%0d got=%0d", $time, name, exp, act));
    end
  endtask

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    report_fail("Run hung, watchdog expired before all frames were done");
  end

  // Producer credit returns
  always @(negedge ac_bclk) begin
    if (rst_n && play_credit.give) begin
      play_gives++;
    end
  end

  // Consumer compares each frame and returns credits unless held
  always @(negedge ac_bclk) begin
    if (rst_n && rec_out.valid) begin
      if (rec_exp.size() == 0) begin
        report_fail("Record frame arrived on rec_out while none was expected");
      end else begin
        check_rec_frame(rec_exp.pop_front(), rec_out.data);
        rec_received++;
        rec_pending++;
      end
    end
    if (!rec_hold && rec_pending > 0) begin
      rec_credit.give = 1'b1;
      rec_pending--;
    end else begin
      rec_credit.give = 1'b0;
    end
  end

  // One push after waiting for a producer credit
  task automatic push_play(input pcm_audio_pkg::stereo_sample_t s);
    while (play_pushes - play_gives >= `PCM_PLAY_DEPTH) @(negedge ac_bclk);
    play_in.valid = 1'b1;
    play_in.data  = s;
    play_pushes++;
    play_exp.push_back(s);
    @(negedge ac_bclk);
    play_in.valid = 1'b0;
  endtask

  // Codec model with 64 data cycles then a sync, n syncs in total
  // Frames at index drop_from and above are expected to be dropped
  task automatic run_frames(input int n, input int drop_from);
    logic [63:0]                   rec_bits;
    logic [63:0]                   play_frame;
    pcm_audio_pkg::stereo_sample_t s;
    pcm_audio_pkg::capture_frame_t f;
    play_frame = '0;
    for (int i = 0; i <= n; i++) begin
      rec_bits = {$urandom, $urandom};
      for (int k = 0; k < 64; k++) begin
        @(negedge ac_bclk);
        ac_pblrc  = 1'b0;
        ac_reclrc = 1'b0;
        // Bit k after the previous sync
        if (i > 0) begin
          check_pbdat(play_frame[63 - k], ac_pbdat);
        end
        ac_recdat = rec_bits[63 - k];
      end
      if (i < n) begin
        @(negedge ac_bclk);
        ac_pblrc  = 1'b1;
        ac_reclrc = 1'b1;
        ac_recdat = 1'b0;
        // Underrun sends silence
        s          = (play_exp.size() > 0) ? play_exp.pop_front() : '0;
        play_frame = play_bits(s, word_length);
        if (i < drop_from) begin
          f.overrun    = next_overrun;
          f.sample     = rec_frame(rec_bits, word_length);
          next_overrun = 1'b0;
          rec_exp.push_back(f);
        end else begin
          next_overrun = 1'b1;
        end
      end
    end
    @(negedge ac_bclk);
    ac_pblrc  = 1'b0;
    ac_reclrc = 1'b0;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    int base_gives;
    int base_rec;
    void'($urandom(32'hb058_2501));
    word_length      = pcm_audio_pkg::WL_16;
    ac_pblrc         = 1'b0;
    ac_reclrc        = 1'b0;
    ac_recdat        = 1'b0;
    play_in          = '0;
    rec_credit.give  = 1'b0;
    @(posedge rst_n);

    // Quiet after reset
    repeat (6) begin
      @(negedge ac_bclk);
      check_pbdat(1'b0, ac_pbdat);
      check_credits("rec_out.valid", 0, int'(rec_out.valid));
      check_credits("play_credit", 0, int'(play_credit.give));
    end

    // Playback and record at every word length
    for (int w = 0; w < 4; w++) begin
      word_length = pcm_audio_pkg::word_length_t'(w);
      base_gives  = play_gives;
      base_rec    = rec_received;
      repeat (6) push_play({$urandom, $urandom});
      run_frames(6, 6);
      repeat (8) @(negedge ac_bclk);
      check_credits("play_credit pulses", base_gives + 6, play_gives);
      check_credits("rec_out frames", base_rec + 6, rec_received);
    end

    // Producer stops early so the tail frames are silent
    word_length = pcm_audio_pkg::WL_16;
    base_gives  = play_gives;
    repeat (3) push_play({$urandom, $urandom});
    run_frames(5, 5);
    repeat (8) @(negedge ac_bclk);
    check_credits("play_credit pulses", base_gives + 3, play_gives);

    // Consumer holds credits until the FIFO fills and later frames drop
    word_length = pcm_audio_pkg::WL_24;
    base_rec    = rec_received;
    rec_hold    = 1'b1;
    run_frames(12, 2 * `PCM_REC_DEPTH);
    repeat (2 * FRAME_CYCLES) @(negedge ac_bclk);
    check_credits("rec_out frames held", base_rec + `PCM_REC_DEPTH, rec_received);
    rec_hold = 1'b0;
    while (rec_received < base_rec + 2 * `PCM_REC_DEPTH) @(negedge ac_bclk);
    check_credits("record frames left", 0, rec_exp.size());

    // First frame after the drop carries overrun
    run_frames(3, 3);
    repeat (8) @(negedge ac_bclk);
    check_credits("rec_out frames", base_rec + 2 * `PCM_REC_DEPTH + 3, rec_received);

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic ac_bclk,
  output logic rst_n
);

  // Free-running bit clock
  initial begin
    ac_bclk = 1'b0;
    forever #(PERIOD_NS / 2) ac_bclk = ~ac_bclk;
  end

  // Reset held for a few rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge ac_bclk);
    @(negedge ac_bclk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* verilog/pcm_audio_port.sv */
`timescale 1ns/10ps
`default_nettype none

`include "pcm_audio_consts.svh"

module pcm_audio_port (
  input  wire logic                        ac_bclk,
  input  wire logic                        rst_n,
  input  wire pcm_audio_pkg::word_length_t word_length,
  // Codec pins
  input  wire logic                        ac_pblrc,
  output logic                             ac_pbdat,
  input  wire logic                        ac_recdat,
  input  wire logic                        ac_reclrc,
  // Producer link
  input  wire pcm_link_pkg::play_push_t    play_in,
  output pcm_link_pkg::credit_t            play_credit,
  // Consumer link
  output pcm_link_pkg::rec_push_t          rec_out,
  input  wire pcm_link_pkg::credit_t       rec_credit
);

  // FIFO to serializer hops
  pcm_link_pkg::play_push_t play_stage;
  pcm_link_pkg::credit_t    play_stage_give;
  pcm_link_pkg::rec_push_t  rec_push;
  pcm_link_pkg::credit_t    rec_push_give;

  ////////////////////////////////
  // Playback buffer, one staging credit downstream
  sample_credit_fifo #(
    .DEPTH        (`PCM_PLAY_DEPTH),
    .INIT_CREDITS (1),
    .payload_t    (pcm_audio_pkg::stereo_sample_t)
  ) play_fifo_i (
    .ac_bclk   (ac_bclk),
    .rst_n     (rst_n),
    .push_valid(play_in.valid),
    .push_data (play_in.data),
    .give_up   (play_credit.give),
    .pop_valid (play_stage.valid),
    .pop_data  (play_stage.data),
    .give_down (play_stage_give.give)
  );

  // Serial side
  dsp_frame_serializer ser_i (
    .ac_bclk    (ac_bclk),
    .rst_n      (rst_n),
    .word_length(word_length),
    .ac_pblrc   (ac_pblrc),
    .ac_pbdat   (ac_pbdat),
    .ac_recdat  (ac_recdat),
    .ac_reclrc  (ac_reclrc),
    .play_in    (play_stage),
    .play_give  (play_stage_give),
    .rec_out    (rec_push),
    .rec_give   (rec_push_give)
  );

  ////////////////////////////////
  // Record buffer, consumer credits downstream
  sample_credit_fifo #(
    .DEPTH        (`PCM_REC_DEPTH),
    .INIT_CREDITS (`PCM_REC_DEPTH),
    .payload_t    (pcm_audio_pkg::capture_frame_t)
  ) rec_fifo_i (
    .ac_bclk   (ac_bclk),
    .rst_n     (rst_n),
    .push_valid(rec_push.valid),
    .push_data (rec_push.data),
    .give_up   (rec_push_give.give),
    .pop_valid (rec_out.valid),
    .pop_data  (rec_out.data),
    .give_down (rec_credit.give)
  );

endmodule

`default_nettype wire

/* verilog/dsp_frame_serializer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "pcm_audio_consts.svh"

module dsp_frame_serializer (
  input  wire logic                        ac_bclk,
  input  wire logic                        rst_n,
  input  wire pcm_audio_pkg::word_length_t word_length,
  // Codec pins, codec is master
  input  wire logic                        ac_pblrc,
  output logic                             ac_pbdat,
  input  wire logic                        ac_recdat,
  input  wire logic                        ac_reclrc,
  // Playback link from the FIFO
  input  wire pcm_link_pkg::play_push_t    play_in,
  output pcm_link_pkg::credit_t            play_give,
  // Record link to the FIFO
  output pcm_link_pkg::rec_push_t          rec_out,
  input  wire pcm_link_pkg::credit_t       rec_give
);

  localparam int FRAME_W = `PCM_FRAME_BITS;
  localparam int CRED_W  = `PCM_CREDIT_BITS;

  pcm_audio_pkg::stereo_sample_t stage_q;
  logic                          stage_full;
  logic [FRAME_W-1:0]            play_frame;
  logic [FRAME_W-1:0]            play_shift_q;
  logic                          play_give_q;

  logic [FRAME_W-1:0]            rec_shift_q;
  pcm_audio_pkg::stereo_sample_t rec_sample;
  pcm_audio_pkg::capture_frame_t rec_data_q;
  logic                          rec_valid_q;
  logic                          rec_send;
  logic                          overrun_pend;
  logic [CRED_W-1:0]             rec_credits;

  //////////////////////////////
  // Playback
  //////////////////////////////

  // Left field first, right right behind it, zeros in the tail
  always_comb begin
    play_frame = '0;
    case (word_length)
      pcm_audio_pkg::WL_16: play_frame[63:32] = {stage_q.left[15:0], stage_q.right[15:0]};
      pcm_audio_pkg::WL_20: play_frame[63:24] = {stage_q.left[19:0], stage_q.right[19:0]};
      pcm_audio_pkg::WL_24: play_frame[63:16] = {stage_q.left[23:0], stage_q.right[23:0]};
      default:              play_frame        = {stage_q.left, stage_q.right};
    endcase
  end

  // Staged sample, read ahead of the next sync
  always_ff @(posedge ac_bclk) begin
    if (play_in.valid) begin
      stage_q <= play_in.data;
    end
  end

  always_ff @(posedge ac_bclk or negedge rst_n) begin
    if (!rst_n) begin
      play_shift_q <= '0;
      stage_full   <= 1'b0;
      play_give_q  <= 1'b0;
    end else begin
      // Slot freed only when a staged sample was taken
      play_give_q <= ac_pblrc && stage_full;
      if (ac_pblrc) begin
        // Empty staging at sync means underrun, send silence
        play_shift_q <= stage_full ? play_frame : '0;
      end else begin
        play_shift_q <= {play_shift_q[FRAME_W-2:0], play_shift_q[FRAME_W-1]};
      end
      if (play_in.valid) begin
        stage_full <= 1'b1;
      end else if (ac_pblrc) begin
        stage_full <= 1'b0;
      end
    end
  end

  assign ac_pbdat       = play_shift_q[FRAME_W-1];
  assign play_give.give = play_give_q;

  //////////////////////////////
  // Record
  //////////////////////////////

  // Same field layout as playback, zero-extended per channel
  always_comb begin
    rec_sample = '0;
    case (word_length)
      pcm_audio_pkg::WL_16: begin
        rec_sample.left[15:0]  = rec_shift_q[63:48];
        rec_sample.right[15:0] = rec_shift_q[47:32];
      end
      pcm_audio_pkg::WL_20: begin
        rec_sample.left[19:0]  = rec_shift_q[63:44];
        rec_sample.right[19:0] = rec_shift_q[43:24];
      end
      pcm_audio_pkg::WL_24: begin
        rec_sample.left[23:0]  = rec_shift_q[63:40];
        rec_sample.right[23:0] = rec_shift_q[39:16];
      end
      default: begin
        rec_sample.left  = rec_shift_q[63:32];
        rec_sample.right = rec_shift_q[31:0];
      end
    endcase
  end

  // Frame goes out only with a credit in hand
  assign rec_send = ac_reclrc && (rec_credits != '0);

  // First bit in ends up as the frame MSB
  always_ff @(posedge ac_bclk) begin
    if (!ac_reclrc) begin
      rec_shift_q <= {rec_shift_q[FRAME_W-2:0], ac_recdat};
    end
    if (rec_send) begin
      rec_data_q.overrun <= overrun_pend;
      rec_data_q.sample  <= rec_sample;
    end
  end

  always_ff @(posedge ac_bclk or negedge rst_n) begin
    if (!rst_n) begin
      rec_valid_q  <= 1'b0;
      overrun_pend <= 1'b0;
      rec_credits  <= CRED_W'(`PCM_REC_DEPTH);
    end else begin
      rec_valid_q <= rec_send;
      // Dropped frame arms the flag, the next sent frame clears it
      if (ac_reclrc) begin
        overrun_pend <= (rec_credits == '0);
      end
      rec_credits <= rec_credits - CRED_W'(rec_valid_q) + CRED_W'(rec_give.give);
    end
  end

  assign rec_out.valid = rec_valid_q;
  assign rec_out.data  = rec_data_q;

  // Playback FIFO holds one credit, so it never refills a full stage
  stage_overwrite_a: assert property (
    @(posedge ac_bclk) disable iff (!rst_n)
    play_in.valid |-> !stage_full
  ) else $error("dsp_frame_serializer: playback beat while staging full");

  // Record FIFO returns no more credits than it has entries
  rec_credit_bound_a: assert property (
    @(posedge ac_bclk) disable iff (!rst_n)
    rec_credits <= CRED_W'(`PCM_REC_DEPTH)
  ) else $error("dsp_frame_serializer: record credits above FIFO depth");

endmodule

`default_nettype wire

/* verilog/sample_credit_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "pcm_audio_consts.svh"

module sample_credit_fifo #(
  parameter int  DEPTH        = 4,
  // Credits granted by the downstream receiver at reset
  parameter int  INIT_CREDITS = DEPTH,
  parameter type payload_t    = logic [`PCM_FRAME_BITS-1:0]
) (
  input  wire logic     ac_bclk,
  input  wire logic     rst_n,
  // Upstream side
  input  wire logic     push_valid,
  input  wire payload_t push_data,
  output logic          give_up,
  // Downstream side
  output logic          pop_valid,
  output payload_t      pop_data,
  input  wire logic     give_down
);

  localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int CRED_W = `PCM_CREDIT_BITS;

  payload_t          mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [CRED_W-1:0] credits;
  logic              do_pop;

  // Head leaves whenever there is one and the receiver has room
  assign do_pop    = (count != '0) && (credits != '0);
  assign pop_valid = do_pop;
  assign pop_data  = mem[rd_ptr];
  // Freed slot goes straight back upstream
  assign give_up   = do_pop;

  // Storage, written on every push
  always_ff @(posedge ac_bclk) begin
    if (push_valid) begin
      mem[wr_ptr] <= push_data;
    end
  end

  //////////////////////////////
  // Pointers and occupancy
  //////////////////////////////
  always_ff @(posedge ac_bclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Push and pop together leave the count alone
      case ({push_valid, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Downstream credits, spent per pop, regained per give
  always_ff @(posedge ac_bclk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= CRED_W'(INIT_CREDITS);
    end else begin
      credits <= credits - CRED_W'(do_pop) + CRED_W'(give_down);
    end
  end

  // Sender must hold a credit per push, so a full FIFO sees no push
  push_when_full_a: assert property (
    @(posedge ac_bclk) disable iff (!rst_n)
    push_valid |-> (count < CNT_W'(DEPTH))
  ) else $error("sample_credit_fifo: push while full, sender broke credit rule");

endmodule

`default_nettype wire

/* verilog/pcm_link_pkg.sv */
`default_nettype none

package pcm_link_pkg;

  //////////////////////////////
  // Credit link beats
  //////////////////////////////

  // Playback beat, one stereo sample
  typedef struct packed {
    logic                          valid;
    pcm_audio_pkg::stereo_sample_t data;
  } play_push_t;

  // Record beat, sample plus overrun marker
  typedef struct packed {
    logic                          valid;
    pcm_audio_pkg::capture_frame_t data;
  } rec_push_t;

  // One pulse returns one credit to the sender
  typedef struct packed {
    logic give;
  } credit_t;

endpackage

`default_nettype wire

/* verilog/pcm_audio_pkg.sv */
`default_nettype none

package pcm_audio_pkg;

  //////////////////////////////
  // Audio format types
  //////////////////////////////

  // Word length per channel, same code for playback and record
  typedef enum logic [1:0] {
    WL_16 = 2'b00,
    WL_20 = 2'b01,
    WL_24 = 2'b10,
    WL_32 = 2'b11
  } word_length_t;

  // Right in the upper half, left in the lower half
  // Samples right-justified, zero-extended above the word length
  typedef struct packed {
    logic [31:0] right;
    logic [31:0] left;
  } stereo_sample_t;

  // Record frame as handed to the consumer
  // Overrun set when frames were dropped just before this one
  typedef struct packed {
    logic           overrun;
    stereo_sample_t sample;
  } capture_frame_t;

endpackage

`default_nettype wire

/* include/pcm_audio_consts.svh */
`ifndef PCM_AUDIO_CONSTS_SVH
`define PCM_AUDIO_CONSTS_SVH

// One stereo frame on the serial line, left then right
`define PCM_FRAME_BITS 64

// Playback FIFO entries, producer credits at reset
`define PCM_PLAY_DEPTH 8

// Record FIFO entries, also the consumer credits at reset
`define PCM_REC_DEPTH 4

// Width of every credit counter
`define PCM_CREDIT_BITS 4

`endif
